// ==== common/dqmPkg.sv ====
package dqmPkg;

    // byte addresses of the host registers.
    typedef enum logic [12:0] {
        regLog10Mse    = 13'h010, // low half is the log result, high half the offset.
        regMseControl  = 13'h014, // low half is the mean, high half the window length.
        regClksPerBit  = 13'h018,
        regPayloadSize = 13'h01C, // alias of the clksPerBit layout.
        regSrcSelect   = 13'h020
    } dqmAddr;

    typedef enum logic {
        mseIdle,
        mseAccum
    } mseState;

    // Largest window exponent accepted by the estimator.
    localparam logic [3:0] maxWindowLog = 4'd12;

    localparam logic [6:0] log10Scale = 7'd77; // log10(2) in q8.

    localparam int sumWidth = 48; // holds 4096 squares of a 16 bit error.
    localparam int meanSqWidth = 32;
    localparam int logWidth = 16;

endpackage

// ==== src/dqmRegs.sv ====
`timescale 1ns/1ps

module dqmRegs (
    input  logic                                busClk,
    input  logic                                rst,
    input  logic        [12:0]                  addr,
    input  logic        [31:0]                  dataIn,
    input  logic                                cs,
    input  logic                                wr0,
    input  logic                                wr1,
    input  logic                                wr2,
    input  logic                                wr3,
    input  logic signed [dqmPkg::logWidth-1:0]  log10Mse,
    output logic        [31:0]                  dataOut,
    output logic signed [15:0]                  log10MseOffset,
    output logic        [15:0]                  mseMean,
    output logic        [3:0]                   windowLog,
    output logic        [13:0]                  payloadSize,
    output logic        [15:0]                  clksPerBit,
    output logic        [3:0]                   sourceSelect,
    output logic        [2:0]                   combinerMode
);

    logic [7:0]  offsetLo;
    logic [7:0]  offsetHi;
    logic [7:0]  meanLo;
    logic [7:0]  meanHi;
    logic [7:0]  avgLenLo;
    logic [7:0]  avgLenHi;
    logic [7:0]  cpbLo;
    logic [7:0]  cpbHi;
    logic [7:0]  payloadLo;
    logic [5:0]  payloadHi;
    logic [15:0] mseAvgLength;

    always_ff @(posedge busClk) begin
        if (rst) begin
            meanLo       <= 8'd0;
            cpbLo        <= 8'd16;
            sourceSelect <= 4'd0;
        end else if (cs && wr0) begin
            case (addr)
                dqmPkg::regMseControl:  meanLo <= dataIn[7:0];
                dqmPkg::regClksPerBit,
                dqmPkg::regPayloadSize: cpbLo <= dataIn[7:0];
                dqmPkg::regSrcSelect:   sourceSelect <= dataIn[3:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge busClk) begin
        if (rst) begin
            meanHi       <= 8'd0;
            cpbHi        <= 8'd0;
            combinerMode <= 3'd0;
        end else if (cs && wr1) begin
            case (addr)
                dqmPkg::regMseControl:  meanHi <= dataIn[15:8];
                dqmPkg::regClksPerBit,
                dqmPkg::regPayloadSize: cpbHi <= dataIn[15:8];
                dqmPkg::regSrcSelect:   combinerMode <= dataIn[10:8];
                default: ;
            endcase
        end
    end

    // The log half of regLog10Mse has no lane process, so host writes to it are lost.
    always_ff @(posedge busClk) begin
        if (rst) begin
            offsetLo  <= 8'd0;
            avgLenLo  <= 8'd4;
            payloadLo <= 8'd0;
        end else if (cs && wr2) begin
            case (addr)
                dqmPkg::regLog10Mse:    offsetLo <= dataIn[23:16];
                dqmPkg::regMseControl:  avgLenLo <= dataIn[23:16];
                dqmPkg::regClksPerBit,
                dqmPkg::regPayloadSize: payloadLo <= dataIn[23:16];
                default: ;
            endcase
        end
    end

    always_ff @(posedge busClk) begin
        if (rst) begin
            offsetHi  <= 8'd0;
            avgLenHi  <= 8'd0;
            payloadHi <= 6'd0;
        end else if (cs && wr3) begin
            case (addr)
                dqmPkg::regLog10Mse:    offsetHi <= dataIn[31:24];
                dqmPkg::regMseControl:  avgLenHi <= dataIn[31:24];
                dqmPkg::regClksPerBit,
                dqmPkg::regPayloadSize: payloadHi <= dataIn[29:24]; // top two bits dropped.
                default: ;
            endcase
        end
    end

    assign log10MseOffset = $signed({offsetHi, offsetLo});
    assign mseMean        = {meanHi, meanLo};
    assign mseAvgLength   = {avgLenHi, avgLenLo};
    assign clksPerBit     = {cpbHi, cpbLo};
    assign payloadSize    = {payloadHi, payloadLo};

    // only the low nibble counts, and anything past the largest window is held there.
    assign windowLog = (mseAvgLength[3:0] > dqmPkg::maxWindowLog) ?
                       dqmPkg::maxWindowLog : mseAvgLength[3:0];

    always_comb begin
        dataOut = 32'd0;
        if (cs) begin
            case (addr)
                dqmPkg::regLog10Mse:    dataOut = {log10MseOffset, log10Mse};
                dqmPkg::regMseControl:  dataOut = {mseAvgLength, mseMean};
                dqmPkg::regClksPerBit,
                dqmPkg::regPayloadSize: dataOut = {2'b00, payloadSize, clksPerBit};
                dqmPkg::regSrcSelect:   dataOut = {21'd0, combinerMode, 4'd0, sourceSelect};
                default:                dataOut = 32'd0;
            endcase
        end
    end

endmodule

// ==== mse/mseEstimator.sv ====
`timescale 1ns/1ps

module mseEstimator #(
    parameter int sampleWidth = 8
) (
    input  logic                                busClk,
    input  logic                                rst,
    input  logic                                sampleValid,
    input  logic signed [sampleWidth-1:0]       sample,
    input  logic        [15:0]                  mseMean,
    input  logic        [3:0]                   windowLog,
    output logic                                meanValid,
    output logic        [dqmPkg::meanSqWidth-1:0] meanSq
);

    dqmPkg::mseState                  state;
    logic [dqmPkg::maxWindowLog:0]    count;
    logic [dqmPkg::maxWindowLog:0]    countNext;
    logic [dqmPkg::maxWindowLog:0]    windowSamples;
    logic [15:0]                      meanLatched;
    logic [3:0]                       winLatched;
    logic [15:0]                      meanUse;
    logic [3:0]                       winUse;
    logic [sampleWidth-1:0]           mag;
    logic signed [17:0]               errVal;
    logic signed [35:0]               errSq;
    logic [dqmPkg::sumWidth-1:0]      sqTerm;
    logic [dqmPkg::sumWidth-1:0]      sum;
    logic [dqmPkg::sumWidth-1:0]      shifted;
    logic                             lastSample;
    logic                             windowDone;

    // The first sample of a window works with the live settings, the rest with the latched ones.
    assign meanUse = (state == dqmPkg::mseIdle) ? mseMean : meanLatched;
    assign winUse  = (state == dqmPkg::mseIdle) ? windowLog : winLatched;

    assign mag    = sample[sampleWidth-1] ? -sample : sample; // the most negative code maps onto 2^(n-1).
    assign errVal = $signed({1'b0, 17'(mag)}) - $signed({2'b00, meanUse});
    assign errSq  = errVal * errVal;
    assign sqTerm = {{(dqmPkg::sumWidth - 36){1'b0}}, errSq};

    assign windowSamples = {{dqmPkg::maxWindowLog{1'b0}}, 1'b1} << winUse;
    assign countNext     = (state == dqmPkg::mseIdle) ? 1 : count + 1'b1;
    assign lastSample    = sampleValid && (countNext == windowSamples);

    assign shifted = sum >> winLatched;

    always_ff @(posedge busClk) begin
        if (rst) begin
            state      <= dqmPkg::mseIdle;
            count      <= '0;
            windowDone <= 1'b0;
            meanValid  <= 1'b0;
        end else begin
            windowDone <= lastSample;
            meanValid  <= windowDone; // one cycle behind the last accumulate.
            if (sampleValid) begin
                count <= countNext;
                state <= lastSample ? dqmPkg::mseIdle : dqmPkg::mseAccum;
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (sampleValid) begin
            if (state == dqmPkg::mseIdle) begin
                sum         <= sqTerm;
                meanLatched <= mseMean;
                winLatched  <= windowLog;
            end else begin
                sum <= sum + sqTerm;
            end
        end
        // A back-to-back window may restart sum on this edge, which still reads the old total.
        if (windowDone) begin
            meanSq <= (|shifted[dqmPkg::sumWidth-1:dqmPkg::meanSqWidth]) ?
                      '1 : shifted[dqmPkg::meanSqWidth-1:0];
        end
    end

endmodule

// ==== mse/mseLog.sv ====
`timescale 1ns/1ps

module mseLog (
    input  logic                                    busClk,
    input  logic                                    rst,
    input  logic                                    meanValid,
    input  logic        [dqmPkg::meanSqWidth-1:0]   meanSq,
    input  logic signed [15:0]                      log10MseOffset,
    output logic signed [dqmPkg::logWidth-1:0]      log10Mse
);

    logic [4:0]                     expo;
    logic [dqmPkg::meanSqWidth+3:0] extended;
    logic [3:0]                     frac;
    logic [8:0]                     log2Value;
    logic [8:0]                     log2Q4;
    logic                           stageValid;
    logic [15:0]                    productQ12;
    logic [15:0]                    scaledQ8;

    function automatic logic [4:0] leadingOne(input logic [dqmPkg::meanSqWidth-1:0] value);
        logic [4:0] pos;
        pos = 5'd0;
        for (int i = 0; i < dqmPkg::meanSqWidth; i++) begin
            if (value[i]) begin
                pos = 5'(i);
            end
        end
        return pos;
    endfunction

    assign expo     = leadingOne(meanSq);
    assign extended = {meanSq, 4'b0000}; // zero fill for bits below bit zero.
    assign frac     = extended[expo +: 4];
    assign log2Value = (meanSq == '0) ? 9'd0 : {expo, frac}; // 16e + f.

    // stage one registers the q4 log2 estimate.
    always_ff @(posedge busClk) begin
        if (rst) begin
            stageValid <= 1'b0;
        end else begin
            stageValid <= meanValid;
        end
    end

    always_ff @(posedge busClk) begin
        if (meanValid) begin
            log2Q4 <= log2Value;
        end
    end

    assign productQ12 = log2Q4 * dqmPkg::log10Scale;
    assign scaledQ8   = {4'd0, productQ12[15:4]};

    // stage two applies the calibration and holds the result until the next window.
    always_ff @(posedge busClk) begin
        if (rst) begin
            log10Mse <= '0;
        end else if (stageValid) begin
            log10Mse <= $signed(scaledQ8) - log10MseOffset;
        end
    end

endmodule

// ==== src/dqmTop.sv ====
`timescale 1ns/1ps

module dqmTop #(
    parameter int sampleWidth = 8
) (
    input  logic                            busClk,
    input  logic                            rst,
    input  logic        [12:0]              addr,
    input  logic        [31:0]              dataIn,
    input  logic                            cs,
    input  logic                            wr0,
    input  logic                            wr1,
    input  logic                            wr2,
    input  logic                            wr3,
    input  logic                            sampleValid,
    input  logic signed [sampleWidth-1:0]   sample,
    output logic        [31:0]              dataOut,
    output logic        [13:0]              payloadSize,
    output logic        [15:0]              clksPerBit,
    output logic        [3:0]               sourceSelect,
    output logic        [2:0]               combinerMode
);

    logic signed [dqmPkg::logWidth-1:0]  log10Mse;
    logic signed [15:0]                  log10MseOffset;
    logic        [15:0]                  mseMean;
    logic        [3:0]                   windowLog;
    logic                                meanValid;
    logic        [dqmPkg::meanSqWidth-1:0] meanSq;

    dqmRegs regs (
        .busClk         (busClk),
        .rst            (rst),
        .addr           (addr),
        .dataIn         (dataIn),
        .cs             (cs),
        .wr0            (wr0),
        .wr1            (wr1),
        .wr2            (wr2),
        .wr3            (wr3),
        .log10Mse       (log10Mse),
        .dataOut        (dataOut),
        .log10MseOffset (log10MseOffset),
        .mseMean        (mseMean),
        .windowLog      (windowLog),
        .payloadSize    (payloadSize),
        .clksPerBit     (clksPerBit),
        .sourceSelect   (sourceSelect),
        .combinerMode   (combinerMode)
    );

    mseEstimator #(
        .sampleWidth (sampleWidth)
    ) estimator (
        .busClk      (busClk),
        .rst         (rst),
        .sampleValid (sampleValid),
        .sample      (sample),
        .mseMean     (mseMean),
        .windowLog   (windowLog),
        .meanValid   (meanValid),
        .meanSq      (meanSq)
    );

    mseLog logUnit (
        .busClk         (busClk),
        .rst            (rst),
        .meanValid      (meanValid),
        .meanSq         (meanSq),
        .log10MseOffset (log10MseOffset),
        .log10Mse       (log10Mse)
    );

endmodule

// ==== sim/dqmTb.sv ====
`timescale 1ns/1ps

module dqmTb;

    localparam int sampleWidth = 8;
    localparam int clkPeriod = 10;
    localparam int winsPerLog = 4;
    // every window the tests run, in samples.
    localparam int totalSamples = winsPerLog * (1 + 4 + 16) + 3 * 16 + (16 + 4) + 4096 + 16;

    logic                          busClk = 1'b0;
    logic                          rst;
    logic [12:0]                   addr;
    logic [31:0]                   dataIn;
    logic                          cs;
    logic                          wr0;
    logic                          wr1;
    logic                          wr2;
    logic                          wr3;
    logic                          sampleValid;
    logic signed [sampleWidth-1:0] sample;
    logic [31:0]                   dataOut;
    logic [13:0]                   payloadSize;
    logic [15:0]                   clksPerBit;
    logic [3:0]                    sourceSelect;
    logic [2:0]                    combinerMode;

    integer      seed = 26;
    int          cyc = 0;
    string       testName = "reset values";
    logic [31:0] shLog;
    logic [31:0] shCtrl;
    logic [31:0] shCpb;
    logic [31:0] shSrc;
    logic [15:0] lastLog;
    int          winData[$];
    int          dueQ[$];
    logic [15:0] expQ[$];

    dqmTop #(.sampleWidth(sampleWidth)) uut (
        .busClk       (busClk),
        .rst          (rst),
        .addr         (addr),
        .dataIn       (dataIn),
        .cs           (cs),
        .wr0          (wr0),
        .wr1          (wr1),
        .wr2          (wr2),
        .wr3          (wr3),
        .sampleValid  (sampleValid),
        .sample       (sample),
        .dataOut      (dataOut),
        .payloadSize  (payloadSize),
        .clksPerBit   (clksPerBit),
        .sourceSelect (sourceSelect),
        .combinerMode (combinerMode)
    );

    always #(clkPeriod / 2) busClk = ~busClk;

    always @(posedge busClk) cyc <= cyc + 1;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkVal(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (expected !== actual) begin
            abortRun($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] laneMerge(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
        logic [31:0] merged;
        merged = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) merged[8*i +: 8] = data[8*i +: 8];
        end
        return merged;
    endfunction

    function automatic void updateShadow(input logic [12:0] a, input logic [31:0] d,
                                         input logic [3:0] strb);
        case (a)
            dqmPkg::regLog10Mse:    shLog = laneMerge(shLog, d, strb) & 32'hFFFF_0000;
            dqmPkg::regMseControl:  shCtrl = laneMerge(shCtrl, d, strb);
            dqmPkg::regClksPerBit,
            dqmPkg::regPayloadSize: shCpb = laneMerge(shCpb, d, strb) & 32'h3FFF_FFFF;
            dqmPkg::regSrcSelect:   shSrc = laneMerge(shSrc, d, strb) & 32'h0000_070F;
            default: ;
        endcase
    endfunction

    function automatic logic [31:0] expRead(input logic [12:0] a);
        case (a)
            dqmPkg::regLog10Mse:    return {shLog[31:16], lastLog};
            dqmPkg::regMseControl:  return shCtrl;
            dqmPkg::regClksPerBit,
            dqmPkg::regPayloadSize: return shCpb;
            dqmPkg::regSrcSelect:   return shSrc;
            default:                return 32'd0;
        endcase
    endfunction

    function automatic int curWindowLog();
        return (shCtrl[19:16] > 4'd12) ? 12 : int'(shCtrl[19:16]); // oversize windows clamp.
    endfunction

    // mean of the squared magnitude errors over the samples of one window.
    function automatic logic [31:0] expMeanSq(input int mean, input int wl);
        longint sumSq;
        longint err;
        int mag;
        sumSq = 0;
        foreach (winData[i]) begin
            mag = (winData[i] < 0) ? -winData[i] : winData[i];
            err = longint'(mag) - longint'(mean);
            sumSq += err * err;
        end
        sumSq = sumSq >> wl;
        if (sumSq > 64'h0000_0000_FFFF_FFFF) return 32'hFFFF_FFFF;
        return sumSq[31:0];
    endfunction

    function automatic logic [15:0] expLog(input logic [31:0] ms, input logic [15:0] off);
        int e;
        int f;
        int l2;
        int l10;
        e = 0;
        l2 = 0;
        if (ms != 32'd0) begin
            for (int i = 0; i < 32; i++) begin
                if (ms[i]) e = i;
            end
            if (e >= 4) f = int'((ms >> (e - 4)) & 32'hF);
            else f = int'((ms << (4 - e)) & 32'hF);
            l2 = 16 * e + f;
        end
        l10 = (l2 * 77) >> 4;
        return 16'(l10) - off;
    endfunction

    task automatic busWrite(input logic [12:0] a, input logic [31:0] d, input logic [3:0] strb);
        @(posedge busClk);
        addr <= a;
        dataIn <= d;
        cs <= 1'b1;
        {wr3, wr2, wr1, wr0} <= strb;
        @(posedge busClk);
        cs <= 1'b0;
        {wr3, wr2, wr1, wr0} <= 4'b0000;
        updateShadow(a, d, strb);
    endtask

    task automatic busRead(input logic [12:0] a, output logic [31:0] d);
        @(posedge busClk);
        addr <= a;
        cs <= 1'b1;
        {wr3, wr2, wr1, wr0} <= 4'b0000;
        @(negedge busClk);
        d = dataOut;
    endtask

    task automatic checkRead(input string name, input logic [12:0] a);
        logic [31:0] d;
        busRead(a, d);
        checkVal(name, expRead(a), d);
    endtask

    task automatic checkExports();
        checkVal("payloadSize port", {18'd0, shCpb[29:16]}, {18'd0, payloadSize});
        checkVal("clksPerBit port", {16'd0, shCpb[15:0]}, {16'd0, clksPerBit});
        checkVal("sourceSelect port", {28'd0, shSrc[3:0]}, {28'd0, sourceSelect});
        checkVal("combinerMode port", {29'd0, shSrc[10:8]}, {29'd0, combinerMode});
    endtask

    task automatic selectLog();
        @(posedge busClk);
        addr <= dqmPkg::regLog10Mse;
        cs <= 1'b1;
        {wr3, wr2, wr1, wr0} <= 4'b0000;
    endtask

    // Drives back-to-back windows and queues the expected log for each one.
    task automatic runWindows(input int count, input bit pauses, input bit zeroData,
                              input int splitAt, input logic [31:0] splitData,
                              input logic [3:0] splitStrb);
        int n;
        int wl;
        int mean;
        logic [31:0] rnd;
        logic signed [sampleWidth-1:0] sv;
        selectLog();
        for (int w = 0; w < count; w++) begin
            wl = curWindowLog();
            mean = int'(shCtrl[15:0]);
            n = 1 << wl;
            winData.delete();
            for (int i = 0; i < n; i++) begin
                if (w == 0 && i == splitAt) begin
                    @(posedge busClk);
                    sampleValid <= 1'b0;
                    busWrite(dqmPkg::regMseControl, splitData, splitStrb);
                    selectLog();
                end
                rnd = $random(seed);
                if (pauses && rnd[9:8] == 2'b00) begin
                    @(posedge busClk);
                    sampleValid <= 1'b0;
                end
                sv = zeroData ? '0 : rnd[sampleWidth-1:0];
                @(posedge busClk);
                sampleValid <= 1'b1;
                sample <= sv;
                winData.push_back(int'(sv));
            end
            dueQ.push_back(cyc + 5); // taken on the next edge, readable three edges later.
            expQ.push_back(expLog(expMeanSq(mean, wl), shLog[31:16]));
        end
        @(posedge busClk);
        sampleValid <= 1'b0;
        while (dueQ.size() > 0) @(posedge busClk);
    endtask

    always @(negedge busClk) begin
        if (dueQ.size() > 0 && dueQ[0] == cyc) begin
            if (!cs || addr != dqmPkg::regLog10Mse) begin
                abortRun("the log register was not selected when a window result was due");
            end
            checkVal(testName, {16'd0, expQ[0]}, {16'd0, dataOut[15:0]});
            lastLog = expQ[0];
            void'(dueQ.pop_front());
            void'(expQ.pop_front());
        end
    end

    initial begin
        #((totalSamples + 2000) * clkPeriod);
        abortRun("watchdog expired before the tests finished");
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] rdAlias;
        rst = 1'b1;
        addr = '0;
        dataIn = '0;
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        sampleValid = 1'b0;
        sample = '0;
        shLog = 32'h0000_0000;
        shCtrl = 32'h0004_0000;
        shCpb = 32'h0000_0010;
        shSrc = 32'h0000_0000;
        lastLog = 16'h0000;
        repeat (8) @(posedge busClk);
        rst <= 1'b0;

        checkRead("reset log10Mse", dqmPkg::regLog10Mse);
        checkRead("reset mseControl", dqmPkg::regMseControl);
        checkRead("reset clksPerBit", dqmPkg::regClksPerBit);
        checkRead("reset payloadSize", dqmPkg::regPayloadSize);
        checkRead("reset srcSelect", dqmPkg::regSrcSelect);
        checkRead("unmapped 0x000", 13'h000);
        checkRead("unmapped 0x024", 13'h024);
        checkRead("unmapped 0x1FFF", 13'h1FFF);
        @(posedge busClk);
        addr <= dqmPkg::regMseControl;
        cs <= 1'b0;
        @(negedge busClk);
        checkVal("read with cs low", 32'd0, dataOut);
        checkExports();

        testName = "byte lanes";
        busWrite(dqmPkg::regSrcSelect, 32'hFFFF_FFFF, 4'b1111);
        checkRead("srcSelect all lanes", dqmPkg::regSrcSelect);
        busWrite(dqmPkg::regSrcSelect, 32'h0000_0500, 4'b0010);
        checkRead("srcSelect lane 1", dqmPkg::regSrcSelect);
        busWrite(dqmPkg::regClksPerBit, 32'h1234_5678, 4'b0001);
        checkRead("clksPerBit lane 0", dqmPkg::regClksPerBit);
        busWrite(dqmPkg::regClksPerBit, 32'hA5A5_A5A5, 4'b0010);
        checkRead("clksPerBit lane 1", dqmPkg::regClksPerBit);
        busWrite(dqmPkg::regPayloadSize, 32'hFFFF_FFFF, 4'b1100);
        busRead(dqmPkg::regClksPerBit, rd);
        busRead(dqmPkg::regPayloadSize, rdAlias);
        checkVal("payloadSize alias", rd, rdAlias);
        checkVal("payloadSize width", 32'h3FFF_A578, rdAlias);
        busWrite(dqmPkg::regLog10Mse, 32'h1234_ABCD, 4'b1111);
        checkRead("log half read only", dqmPkg::regLog10Mse);
        busWrite(dqmPkg::regLog10Mse, 32'h0000_0000, 4'b1100);
        busWrite(dqmPkg::regMseControl, 32'hAB00_0000, 4'b1000);
        checkRead("mseControl lane 3", dqmPkg::regMseControl);
        checkExports();

        testName = "window averaging";
        for (int k = 0; k < 3; k++) begin
            busWrite(dqmPkg::regMseControl, {16'(2 * k), 16'h0028}, 4'b1111);
            runWindows(winsPerLog, 1'b1, 1'b0, -1, 32'd0, 4'd0);
        end

        testName = "offset";
        busWrite(dqmPkg::regLog10Mse, 32'h012C_0000, 4'b1100);
        runWindows(2, 1'b1, 1'b0, -1, 32'd0, 4'd0);
        busWrite(dqmPkg::regLog10Mse, 32'h07D0_0000, 4'b1100);
        runWindows(1, 1'b1, 1'b0, -1, 32'd0, 4'd0);
        busRead(dqmPkg::regLog10Mse, rd);
        checkVal("negative result", 32'd1, {31'd0, rd[15]});
        checkRead("offset readback", dqmPkg::regLog10Mse);

        testName = "mid-window change";
        runWindows(2, 1'b0, 1'b0, 5, 32'h0002_0000, 4'b0100);

        testName = "clamped window";
        busWrite(dqmPkg::regMseControl, 32'h000F_0000, 4'b1100);
        checkRead("mseAvgLength readback", dqmPkg::regMseControl);
        runWindows(1, 1'b0, 1'b0, -1, 32'd0, 4'd0);

        testName = "zero window";
        busWrite(dqmPkg::regMseControl, 32'h0004_0000, 4'b1111);
        runWindows(1, 1'b0, 1'b1, -1, 32'd0, 4'd0);
        busRead(dqmPkg::regLog10Mse, rd);
        checkVal("zero mean over zero samples", 32'h0000_F830, {16'd0, rd[15:0]});
        checkExports();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== sim.f ====
common/dqmPkg.sv
src/dqmRegs.sv
mse/mseEstimator.sv
mse/mseLog.sv
src/dqmTop.sv
sim/dqmTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module dqmTb -f sim.f -o dqmSim \
    && ./obj_dir/dqmSim \
    || { echo "simulation failed"; exit 1; }
